// ==== build.f ====
riscv_pkg.sv
uop_if.sv
inst_decoder.sv
check.sv
issue_scheduler.sv
frontend_top.sv
tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the frontend testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_frontend -o tb_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_frontend.sv ====
`default_nettype none

module tb_frontend;

    localparam int timeout_cycles = 200;

    // Expected issue fields of one instruction.
    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;
        logic [11:0] csr;
    } uop_t;

    logic        CLK;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        flush;
    logic        mem_wait;
    logic        wb_valid = 1'b0;
    logic [4:0]  wb_rd = 5'd0;
    logic        ready;
    logic        issue_valid;
    logic [31:0] issue_pc;
    logic [6:0]  issue_opcode;
    logic [4:0]  issue_rd;
    logic [4:0]  issue_rs1;
    logic [4:0]  issue_rs2;
    logic [11:0] issue_csr;
    logic [2:0]  issue_funct3;
    logic [6:0]  issue_funct7;
    logic [31:0] issue_imm;

    int    seed = 63676;
    uop_t  exp_q[$];  // Every accepted instruction, in order.
    int    acc_q[$];
    uop_t  seen;
    int    issue_idx = 0;
    int    flush_mark = 0;
    int    cycle = 0;
    int    chk_err = 0;
    int    main_err = 0;
    int    test_err_base = 0;
    int    tests = 0;
    int    passed = 0;
    string test_name = "reset";
    bit    check_latency = 1'b0;
    bit    rand_wait = 1'b0;
    bit    wb_hold = 1'b0;

    int    wb_log_rd[$];
    int    wb_log_due[$];
    int    pend_rd[$];
    int    pend_due[$];
    int    log_idx = 0;
    int    wb_sent = 0;
    int    due_at;

    frontend_top uut (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic uop_t decode_ref(input logic [31:0] w, input logic [31:0] addr);
        uop_t u;
        u.pc     = addr;
        u.opcode = w[6:0];
        u.rd     = w[11:7];
        u.rs1    = w[19:15];
        u.rs2    = 5'd0;
        u.funct3 = w[14:12];
        u.funct7 = w[31:25];
        u.imm    = 32'd0;
        case (w[6:0])
            riscv_pkg::opcode_lui, riscv_pkg::opcode_auipc: begin
                u.imm = {w[31:12], 12'd0};
                u.rs1 = 5'd0;
            end
            riscv_pkg::opcode_jal: begin
                u.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                u.rs1 = 5'd0;
            end
            riscv_pkg::opcode_jalr, riscv_pkg::opcode_load,
            riscv_pkg::opcode_op_imm, riscv_pkg::opcode_system:
                u.imm = {{20{w[31]}}, w[31:20]};
            riscv_pkg::opcode_store: begin
                u.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                u.rd  = 5'd0;
                u.rs2 = w[24:20];
            end
            riscv_pkg::opcode_branch: begin
                u.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                u.rd  = 5'd0;
                u.rs2 = w[24:20];
            end
            riscv_pkg::opcode_op:
                u.rs2 = w[24:20];
            default: ; // Unknown opcodes keep a zero immediate.
        endcase
        u.csr = u.imm[11:0];
        return u;
    endfunction

    function automatic logic [6:0] pick_opcode(input int k);
        case (k)
            0: return riscv_pkg::opcode_lui;
            1: return riscv_pkg::opcode_auipc;
            2: return riscv_pkg::opcode_jal;
            3: return riscv_pkg::opcode_jalr;
            4: return riscv_pkg::opcode_branch;
            5: return riscv_pkg::opcode_load;
            6: return riscv_pkg::opcode_store;
            7: return riscv_pkg::opcode_op_imm;
            8: return riscv_pkg::opcode_op;
            default: return riscv_pkg::opcode_system;
        endcase
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] op, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:25], rs2, rs1, r[14:12], rd, op};
    endfunction

    task automatic check_field(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: %s expected %h actual %h", test_name, field, expected, actual);
            chk_err++;
        end
    endtask

    // Comparing process, sampled half a cycle away from the drive edge.
    always @(negedge CLK) begin
        if (issue_idx < flush_mark) begin
            issue_idx = flush_mark; // Flushed entries never issue.
        end
        if (rst_n && issue_valid) begin
            if (issue_idx >= exp_q.size()) begin
                $display("%s: pc %h issued with no instruction expected", test_name, issue_pc);
                chk_err++;
            end else begin
                seen = exp_q[issue_idx];
                check_field("pc", seen.pc, issue_pc);
                check_field("opcode", 32'(seen.opcode), 32'(issue_opcode));
                check_field("rd", 32'(seen.rd), 32'(issue_rd));
                check_field("rs1", 32'(seen.rs1), 32'(issue_rs1));
                check_field("rs2", 32'(seen.rs2), 32'(issue_rs2));
                check_field("funct3", 32'(seen.funct3), 32'(issue_funct3));
                check_field("funct7", 32'(seen.funct7), 32'(issue_funct7));
                check_field("imm", seen.imm, issue_imm);
                check_field("csr", 32'(seen.csr), 32'(issue_csr));
                if (check_latency && cycle - acc_q[issue_idx] != 2) begin
                    $display("error %s: latency of pc %h expected 2 actual %0d",
                             test_name, issue_pc, cycle - acc_q[issue_idx]);
                    chk_err++;
                end
                issue_idx++;
            end
            if (issue_rd != 5'd0) begin
                wb_log_rd.push_back(32'(issue_rd));
                wb_log_due.push_back(cycle + 1 + int'({$random(seed)} % 6));
            end
        end
    end

    // Writeback model, one register per cycle.
    always @(posedge CLK) begin
        cycle++;
        while (log_idx < wb_log_rd.size()) begin
            pend_rd.push_back(wb_log_rd[log_idx]);
            pend_due.push_back(wb_log_due[log_idx]);
            log_idx++;
        end
        due_at = -1;
        if (!wb_hold) begin
            for (int i = 0; i < pend_rd.size(); i++) begin
                if (due_at < 0 && pend_due[i] <= cycle) begin
                    due_at = i;
                end
            end
        end
        if (due_at >= 0) begin
            wb_valid <= 1'b1;
            wb_rd    <= 5'(pend_rd[due_at]);
            pend_rd.delete(due_at);
            pend_due.delete(due_at);
            wb_sent++;
        end else begin
            wb_valid <= 1'b0;
        end
    end

    // Called just after a rising edge, returns just after the accepting edge.
    task automatic send_inst(input logic [31:0] w, input logic [31:0] addr);
        int waited;
        bit accepted;
        waited   = 0;
        accepted = 1'b0;
        inst_valid <= 1'b1;
        inst       <= w;
        pc         <= addr;
        if (rand_wait) begin
            mem_wait <= (($random(seed) & 3) == 0);
        end
        while (!accepted && waited < timeout_cycles) begin
            @(negedge CLK);
            if (ready) begin
                exp_q.push_back(decode_ref(w, addr));
                acc_q.push_back(cycle);
                accepted = 1'b1;
            end
            @(posedge CLK);
            waited++;
            if (!accepted && rand_wait) begin
                mem_wait <= (($random(seed) & 3) == 0);
            end
        end
        if (!accepted) begin
            $display("%s: instruction at pc %h was never accepted", test_name, addr);
            main_err++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        inst_valid <= 1'b0;
        mem_wait   <= 1'b0;
        while (issue_idx < exp_q.size() && waited < timeout_cycles) begin
            @(posedge CLK);
            waited++;
        end
        if (issue_idx < exp_q.size()) begin
            $display("%s: %0d accepted instructions never issued", test_name,
                     exp_q.size() - issue_idx);
            main_err++;
        end
        waited = 0;
        while (wb_sent < wb_log_rd.size() && waited < timeout_cycles) begin
            @(negedge CLK);
            waited++;
        end
        if (wb_sent < wb_log_rd.size()) begin
            $display("%s: writebacks still pending at the end of the wait", test_name);
            main_err++;
        end
        @(posedge CLK);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = chk_err + main_err;
    endtask

    task automatic end_test();
        int errs;
        errs = chk_err + main_err - test_err_base;
        tests++;
        if (errs == 0) begin
            passed++;
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errs);
        end
    endtask

    initial begin
        logic [31:0] next_pc;
        logic [31:0] r;
        logic [6:0]  op;
        int          waited;
        rst_n      <= 1'b0;
        inst_valid <= 1'b0;
        inst       <= 32'd0;
        pc         <= 32'd0;
        flush      <= 1'b0;
        mem_wait   <= 1'b0;
        next_pc = 32'h0000_1000;
        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;
        @(posedge CLK);

        start_test("formats");
        @(negedge CLK);
        if (!ready || issue_valid) begin
            $display("formats: ready low or issue_valid high after reset");
            main_err++;
        end
        @(posedge CLK);
        for (int k = 0; k < 10; k++) begin
            send_inst(make_inst(pick_opcode(k), 5'(k + 1), 5'(k + 16), 5'(k + 20)), next_pc);
            next_pc += 4;
        end
        send_inst({12'h305, 5'd16, 3'b001, 5'd3, riscv_pkg::opcode_system}, next_pc);
        next_pc += 4;
        drain();
        end_test();

        start_test("stream");
        check_latency = 1'b1;
        for (int i = 0; i < 50; i++) begin
            op = pick_opcode(int'({$random(seed)} % 10));
            send_inst(make_inst(op, 5'(1 + i % 15), 5'(16 + i % 16), 5'(16 + (i + 5) % 16)),
                      next_pc);
            next_pc += 4;
        end
        drain();
        check_latency = 1'b0;
        end_test();

        start_test("raw_hazard");
        wb_hold = 1'b1; // Producer's writeback waits until released below.
        send_inst(make_inst(riscv_pkg::opcode_op_imm, 5'd7, 5'd16, 5'd17), next_pc);
        send_inst(make_inst(riscv_pkg::opcode_op, 5'd8, 5'd7, 5'd18), next_pc + 4);
        next_pc += 8;
        inst_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (ready && waited < timeout_cycles);
        if (ready) begin
            $display("raw_hazard: ready never went low behind the producer");
            main_err++;
        end
        repeat (10) begin
            @(negedge CLK);
            if (ready || issue_valid) begin
                $display("raw_hazard: consumer left the stall before the writeback");
                main_err++;
            end
        end
        wb_hold = 1'b0;
        @(posedge CLK);
        drain();
        end_test();

        start_test("flush");
        send_inst(make_inst(riscv_pkg::opcode_op, 5'd9, 5'd20, 5'd21), next_pc);
        send_inst(make_inst(riscv_pkg::opcode_load, 5'd10, 5'd22, 5'd0), next_pc + 4);
        next_pc += 8;
        inst_valid <= 1'b0;
        mem_wait   <= 1'b1; // Keeps the older one from issuing before the flush lands.
        flush      <= 1'b1;
        flush_mark = exp_q.size();
        @(posedge CLK);
        flush    <= 1'b0;
        mem_wait <= 1'b0;
        repeat (4) begin
            @(negedge CLK);
            if (issue_valid) begin
                $display("flush: an instruction issued after the flush");
                main_err++;
            end
        end
        @(posedge CLK);
        send_inst(make_inst(riscv_pkg::opcode_op_imm, 5'd11, 5'd23, 5'd0), next_pc);
        next_pc += 4;
        drain();
        end_test();

        start_test("mem_wait");
        send_inst(make_inst(riscv_pkg::opcode_op, 5'd12, 5'd24, 5'd25), next_pc);
        send_inst(make_inst(riscv_pkg::opcode_store, 5'd0, 5'd26, 5'd27), next_pc + 4);
        next_pc += 8;
        inst_valid <= 1'b0;
        mem_wait   <= 1'b1;
        repeat (8) begin
            @(negedge CLK);
            if (ready || issue_valid) begin
                $display("mem_wait: ready or issue_valid high while mem_wait is held");
                main_err++;
            end
        end
        @(posedge CLK);
        drain();
        end_test();

        start_test("random");
        rand_wait = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r  = $random(seed);
            op = (r[19:16] < 4'd10) ? pick_opcode(int'(r[19:16])) : 7'b1111011;
            send_inst(make_inst(op, r[4:0], r[9:5], r[14:10]), next_pc);
            next_pc += 4;
        end
        rand_wait = 1'b0;
        drain();
        if (issue_idx != exp_q.size()) begin
            $display("random: expected queue not empty at the end");
            main_err++;
        end
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests, passed,
                 tests - passed, chk_err + main_err);
        if (chk_err + main_err == 0 && passed == tests) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== frontend_top.sv ====
`default_nettype none

module frontend_top (
    input wire                         CLK,
    input wire                         rst_n,
    input wire                         inst_valid,
    input wire riscv_pkg::inst_u       inst,
    input wire [riscv_pkg::xlen-1:0]   pc,
    input wire                         flush,
    input wire                         mem_wait,
    input wire                         wb_valid,
    input wire [4:0]                   wb_rd,
    output logic                       ready,
    output logic                       issue_valid,
    output logic [riscv_pkg::xlen-1:0] issue_pc,
    output logic [6:0]                 issue_opcode,
    output logic [4:0]                 issue_rd,
    output logic [4:0]                 issue_rs1,
    output logic [4:0]                 issue_rs2,
    output logic [11:0]                issue_csr,
    output logic [2:0]                 issue_funct3,
    output logic [6:0]                 issue_funct7,
    output logic [riscv_pkg::xlen-1:0] issue_imm
);

    logic stall;

    uop_if dec_bus ();
    uop_if chk_bus ();

    assign ready = ~(stall | mem_wait); // Decoder can take a word this cycle.

    inst_decoder u_decoder (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .flush      (flush),
        .stall      (stall),
        .mem_wait   (mem_wait),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .dec        (dec_bus.src)
    );

    check u_check (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .dec      (dec_bus.snk),
        .chk      (chk_bus.src)
    );

    issue_scheduler u_scheduler (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .mem_wait     (mem_wait),
        .chk          (chk_bus.snk),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .stall        (stall),
        .issue_valid  (issue_valid),
        .issue_pc     (issue_pc),
        .issue_opcode (issue_opcode),
        .issue_rd     (issue_rd),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_csr    (issue_csr),
        .issue_funct3 (issue_funct3),
        .issue_funct7 (issue_funct7),
        .issue_imm    (issue_imm)
    );

endmodule

`default_nettype wire

// ==== issue_scheduler.sv ====
`default_nettype none

module issue_scheduler (
    input wire                         CLK,
    input wire                         rst_n,
    input wire                         mem_wait,
    uop_if.snk                         chk,
    input wire                         wb_valid,
    input wire [4:0]                   wb_rd,
    output logic                       stall,
    output logic                       issue_valid,
    output logic [riscv_pkg::xlen-1:0] issue_pc,
    output logic [6:0]                 issue_opcode,
    output logic [4:0]                 issue_rd,
    output logic [4:0]                 issue_rs1,
    output logic [4:0]                 issue_rs2,
    output logic [11:0]                issue_csr,
    output logic [2:0]                 issue_funct3,
    output logic [6:0]                 issue_funct7,
    output logic [riscv_pkg::xlen-1:0] issue_imm
);

    logic [31:0] busy;
    logic [31:0] busy_next;
    logic        src_busy;

    // x0 never gets set, so it never blocks.
    assign src_busy = busy[chk.rs1] | busy[chk.rs2];

    assign issue_valid = chk.valid & ~src_busy & ~mem_wait;
    assign stall       = chk.valid & ~issue_valid;

    always_comb begin
        busy_next = busy;
        if (wb_valid) begin
            busy_next[wb_rd] = 1'b0;
        end
        if (issue_valid && chk.rd != 5'd0) begin
            busy_next[chk.rd] = 1'b1; // Set wins over a same-cycle writeback.
        end
        busy_next[0] = 1'b0;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            busy <= 32'd0;
        end else begin
            busy <= busy_next;
        end
    end

    assign issue_pc     = chk.pc;
    assign issue_opcode = chk.opcode;
    assign issue_rd     = chk.rd;
    assign issue_rs1    = chk.rs1;
    assign issue_rs2    = chk.rs2;
    assign issue_csr    = chk.csr;
    assign issue_funct3 = chk.funct3;
    assign issue_funct7 = chk.funct7;
    assign issue_imm    = chk.imm;

endmodule

`default_nettype wire

// ==== check.sv ====
`default_nettype none

module check (
    input wire CLK,
    input wire rst_n,
    input wire flush,
    input wire stall,
    input wire mem_wait,
    uop_if.snk dec,
    uop_if.src chk
);

    logic                       valid_q;
    logic [riscv_pkg::xlen-1:0] pc_q;
    logic [6:0]                 opcode_q;
    logic [4:0]                 rd_q;
    logic [4:0]                 rs1_q;
    logic [4:0]                 rs2_q;
    logic [2:0]                 funct3_q;
    logic [6:0]                 funct7_q;
    logic [riscv_pkg::xlen-1:0] imm_q;

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            valid_q  <= 1'b0;
            pc_q     <= '0;
            opcode_q <= 7'd0;
            rd_q     <= 5'd0;
            rs1_q    <= 5'd0;
            rs2_q    <= 5'd0;
            funct3_q <= 3'd0;
            funct7_q <= 7'd0;
            imm_q    <= '0;
        end else if (!(stall || mem_wait)) begin
            valid_q  <= dec.valid;
            pc_q     <= dec.pc;
            opcode_q <= dec.opcode;
            rd_q     <= dec.rd;
            rs1_q    <= dec.rs1;
            rs2_q    <= dec.rs2;
            funct3_q <= dec.funct3;
            funct7_q <= dec.funct7;
            imm_q    <= dec.imm;
        end
    end

    assign chk.valid  = valid_q;
    assign chk.pc     = pc_q;
    assign chk.opcode = opcode_q;
    assign chk.rd     = rd_q;
    assign chk.rs1    = rs1_q;
    assign chk.rs2    = rs2_q;
    assign chk.funct3 = funct3_q;
    assign chk.funct7 = funct7_q;
    assign chk.imm    = imm_q;

    // CSR address sits in the I-type immediate field.
    assign chk.csr = imm_q[11:0];

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input wire                       CLK,
    input wire                       rst_n,
    input wire                       flush,
    input wire                       stall,
    input wire                       mem_wait,
    input wire                       inst_valid,
    input wire riscv_pkg::inst_u     inst,
    input wire [riscv_pkg::xlen-1:0] pc,
    uop_if.src                       dec
);

    localparam int ext_i = riscv_pkg::xlen - 12;
    localparam int ext_s = riscv_pkg::xlen - 12;
    localparam int ext_b = riscv_pkg::xlen - 13;
    localparam int ext_j = riscv_pkg::xlen - 21;

    logic [riscv_pkg::xlen-1:0] imm_d;
    logic [4:0]                 rd_d;
    logic [4:0]                 rs1_d;
    logic [4:0]                 rs2_d;
    logic [6:0]                 opcode;
    logic                       hold;

    logic                       valid_q;
    logic [riscv_pkg::xlen-1:0] pc_q;
    logic [6:0]                 opcode_q;
    logic [4:0]                 rd_q;
    logic [4:0]                 rs1_q;
    logic [4:0]                 rs2_q;
    logic [2:0]                 funct3_q;
    logic [6:0]                 funct7_q;
    logic [riscv_pkg::xlen-1:0] imm_q;

    assign opcode = inst.r_fmt.opcode;
    assign hold   = stall | mem_wait;

    // Immediate per format.
    always_comb begin
        case (opcode)
            riscv_pkg::opcode_jalr,
            riscv_pkg::opcode_load,
            riscv_pkg::opcode_op_imm,
            riscv_pkg::opcode_system:
                imm_d = {{ext_i{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            riscv_pkg::opcode_store:
                imm_d = {{ext_s{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                         inst.s_fmt.imm_4_0};
            riscv_pkg::opcode_branch:
                imm_d = {{ext_b{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                         inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            riscv_pkg::opcode_lui,
            riscv_pkg::opcode_auipc:
                imm_d = {inst.u_fmt.imm_31_12, 12'b0};
            riscv_pkg::opcode_jal:
                imm_d = {{ext_j{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                         inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default:
                imm_d = '0; // R-type and unknown opcodes.
        endcase
    end

    // Keep only registers the instruction really touches.
    always_comb begin
        rd_d  = inst.r_fmt.rd;
        rs1_d = inst.r_fmt.rs1;
        rs2_d = 5'd0;
        case (opcode)
            riscv_pkg::opcode_store,
            riscv_pkg::opcode_branch: begin
                rd_d  = 5'd0;
                rs2_d = inst.r_fmt.rs2;
            end
            riscv_pkg::opcode_op:
                rs2_d = inst.r_fmt.rs2;
            riscv_pkg::opcode_lui,
            riscv_pkg::opcode_auipc,
            riscv_pkg::opcode_jal:
                rs1_d = 5'd0;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0; // Flush beats stall.
        end else if (!hold) begin
            valid_q <= inst_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            pc_q     <= pc;
            opcode_q <= opcode;
            rd_q     <= rd_d;
            rs1_q    <= rs1_d;
            rs2_q    <= rs2_d;
            funct3_q <= inst.r_fmt.funct3;
            funct7_q <= inst.r_fmt.funct7;
            imm_q    <= imm_d;
        end
    end

    assign dec.valid  = valid_q;
    assign dec.pc     = pc_q;
    assign dec.opcode = opcode_q;
    assign dec.rd     = rd_q;
    assign dec.rs1    = rs1_q;
    assign dec.rs2    = rs2_q;
    assign dec.funct3 = funct3_q;
    assign dec.funct7 = funct7_q;
    assign dec.imm    = imm_q;
    assign dec.csr    = 12'd0; // Filled in by the check stage.

endmodule

`default_nettype wire

// ==== uop_if.sv ====
`default_nettype none

// One decoded instruction moving between two stages.
interface uop_if;

    logic                       valid;
    logic [riscv_pkg::xlen-1:0] pc;
    logic [6:0]                 opcode;
    logic [4:0]                 rd;
    logic [4:0]                 rs1;
    logic [4:0]                 rs2;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [riscv_pkg::xlen-1:0] imm;
    logic [11:0]                csr;

    modport src (
        output valid, pc, opcode, rd, rs1, rs2, funct3, funct7, imm, csr
    );

    modport snk (
        input valid, pc, opcode, rd, rs1, rs2, funct3, funct7, imm, csr
    );

endinterface

`default_nettype wire

// ==== riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    localparam int xlen = 32;

    // RV32I major opcodes.
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero.
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, seen through each encoding format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

`default_nettype wire
